/* fifo_config.svh */
`ifndef FIFO_CONFIG_SVH
`define FIFO_CONFIG_SVH

// ********************
// FIFO geometry
// ********************

// Width of one data word.
`define FIFO_DATA_W 8

// Number of RAM entries, a power of two.
`define FIFO_DEPTH 16

// RAM address width, log2 of the depth.
`define FIFO_ADDR_W 4

// Pointers carry one extra wrap bit.
`define FIFO_PTR_W (`FIFO_ADDR_W + 1)

// ********************
// Flag thresholds
// ********************

// In used entries.
`define FIFO_AFULL 15
`define FIFO_AEMPTY 1

`endif

/* fifo_pkg.sv */
`include "fifo_config.svh"

package fifo_pkg;

  // ********************
  // Data
  // ********************

  typedef logic [`FIFO_DATA_W-1:0] fifo_data_t;

  // ********************
  // Pointers
  // ********************

  // Wrap bit above the RAM index.
  typedef struct packed {
    logic                   wrap;
    logic [`FIFO_ADDR_W-1:0] index;
  } fifo_ptr_fields_t;

  // One pointer word, seen either as a plain count for arithmetic
  // or split into wrap and index for addressing and full detection.
  typedef union packed {
    logic [`FIFO_PTR_W-1:0] count;
    fifo_ptr_fields_t       fields;
  } fifo_ptr_u;

endpackage

/* ptr_sync.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module ptr_sync (
  input  logic                   dst_clk,
  input  logic                   dst_rst_n,
  input  logic [`FIFO_PTR_W-1:0] gray_in,
  output fifo_pkg::fifo_ptr_u    bin_out
);

  logic [`FIFO_PTR_W-1:0] sync_q1;
  logic [`FIFO_PTR_W-1:0] sync_q2;
  logic [`FIFO_PTR_W-1:0] bin_val;

  // ********************
  // Two-flop synchronizer
  // ********************

  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;
      sync_q2 <= sync_q1;
    end
  end

  // ********************
  // Gray to binary
  // ********************

  // Each binary bit is the XOR of the Gray bits at and above it.
  always_comb begin
    bin_val = '0;
    for (int i = 0; i < `FIFO_PTR_W; i++) begin
      bin_val[i] = ^(sync_q2 >> i);
    end
  end

  assign bin_out.count = bin_val;

endmodule

/* fifo_wr_ctrl.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_wr_ctrl (
  input  logic                    wr_clk,
  input  logic                    wr_rst_n,
  input  logic                    wr_en,
  input  logic [`FIFO_PTR_W-1:0]  rd_gray,
  output logic [`FIFO_PTR_W-1:0]  wr_gray,
  output logic                    wr_accept,
  output logic [`FIFO_ADDR_W-1:0] wr_index,
  output logic                    full,
  output logic                    afull
);

  fifo_pkg::fifo_ptr_u    wr_ptr;
  fifo_pkg::fifo_ptr_u    wr_next;
  fifo_pkg::fifo_ptr_u    rd_sync;
  logic [`FIFO_PTR_W-1:0] wr_used;
  logic [`FIFO_PTR_W-1:0] wr_used_next;

  // Read pointer brought into the write domain.
  ptr_sync u_rd_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_gray),
    .bin_out   (rd_sync)
  );

  // ********************
  // Write pointer
  // ********************

  assign wr_accept = wr_en && !full;
  assign wr_index  = wr_ptr.fields.index;

  always_comb begin
    wr_next = wr_ptr;
    if (wr_accept) begin
      wr_next.count = wr_ptr.count + 1'b1;
    end
  end

  // Level as seen from the write side, pessimistic while the read
  // pointer is in flight.
  assign wr_used      = wr_ptr.count - rd_sync.count;
  assign wr_used_next = wr_next.count - rd_sync.count;

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else begin
      wr_ptr  <= wr_next;
      wr_gray <= wr_next.count ^ (wr_next.count >> 1);
    end
  end

  // ********************
  // Flags
  // ********************

  // Full when the pointers sit on the same index one lap apart.
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= (wr_next.fields.wrap != rd_sync.fields.wrap) &&
               (wr_next.fields.index == rd_sync.fields.index);
      afull <= wr_used_next >= `FIFO_AFULL;
    end
  end

  // ********************
  // Assertions
  // ********************

  // Only one bit may move per cycle or the synchronizer can tear.
  a_wr_gray_step: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    $countones(wr_gray ^ $past(wr_gray)) <= 1
  );

  // the write pointer never laps the read pointer
  a_wr_used_max: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
    wr_used <= `FIFO_DEPTH
  );

endmodule

/* fifo_rd_ctrl.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_rd_ctrl (
  input  logic                    rd_clk,
  input  logic                    rd_rst_n,
  input  logic                    rd_en,
  input  logic [`FIFO_PTR_W-1:0]  wr_gray,
  output logic [`FIFO_PTR_W-1:0]  rd_gray,
  output logic                    rd_accept,
  output logic [`FIFO_ADDR_W-1:0] rd_index,
  output logic                    empty,
  output logic                    aempty
);

  fifo_pkg::fifo_ptr_u    rd_ptr;
  fifo_pkg::fifo_ptr_u    rd_next;
  fifo_pkg::fifo_ptr_u    wr_sync;
  logic [`FIFO_PTR_W-1:0] rd_used;
  logic [`FIFO_PTR_W-1:0] rd_used_next;

  // Write pointer brought into the read domain.
  ptr_sync u_wr_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_gray),
    .bin_out   (wr_sync)
  );

  // ********************
  // Read pointer
  // ********************

  assign rd_accept = rd_en && !empty;
  assign rd_index  = rd_ptr.fields.index;

  always_comb begin
    rd_next = rd_ptr;
    if (rd_accept) begin
      rd_next.count = rd_ptr.count + 1'b1;
    end
  end

  // Level as seen from the read side, low while new writes are
  // still crossing over.
  assign rd_used      = wr_sync.count - rd_ptr.count;
  assign rd_used_next = wr_sync.count - rd_next.count;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else begin
      rd_ptr  <= rd_next;
      rd_gray <= rd_next.count ^ (rd_next.count >> 1);
    end
  end

  // ********************
  // Flags
  // ********************

  // Empty when both pointers match, wrap bit included.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= rd_next.count == wr_sync.count;
      aempty <= rd_used_next <= `FIFO_AEMPTY;
    end
  end

  // ********************
  // Assertions
  // ********************

  // Only one bit may move per cycle or the synchronizer can tear.
  a_rd_gray_step: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    $countones(rd_gray ^ $past(rd_gray)) <= 1
  );

  // A read pointer ahead of the write pointer wraps the level past the depth.
  a_rd_no_pass: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    rd_used <= `FIFO_DEPTH
  );

endmodule

/* fifo_dpram.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module fifo_dpram (
  input  logic                    wr_clk,
  input  logic                    wr_accept,
  input  logic [`FIFO_ADDR_W-1:0] wr_index,
  input  fifo_pkg::fifo_data_t    wr_data,
  input  logic                    rd_clk,
  input  logic                    rd_rst_n,
  input  logic                    rd_accept,
  input  logic [`FIFO_ADDR_W-1:0] rd_index,
  output fifo_pkg::fifo_data_t    rd_data
);

  fifo_pkg::fifo_data_t mem [`FIFO_DEPTH];

  // ********************
  // Write port
  // ********************

  always_ff @(posedge wr_clk) begin
    if (wr_accept) begin
      mem[wr_index] <= wr_data;
    end
  end

  // ********************
  // Read port
  // ********************

  // Output register holds the last word read until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_accept) begin
      rd_data <= mem[rd_index];
    end
  end

endmodule

/* async_fifo.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module async_fifo (
  input  logic                 wr_clk,
  input  logic                 wr_rst_n,
  input  logic                 wr_en,
  input  fifo_pkg::fifo_data_t wr_data,
  input  logic                 rd_clk,
  input  logic                 rd_rst_n,
  input  logic                 rd_en,
  output fifo_pkg::fifo_data_t rd_data,
  output logic                 full,
  output logic                 afull,
  output logic                 empty,
  output logic                 aempty
);

  // Gray pointers crossing between the domains.
  logic [`FIFO_PTR_W-1:0]  wr_gray;
  logic [`FIFO_PTR_W-1:0]  rd_gray;

  // Accepted accesses toward the RAM.
  logic                    wr_accept;
  logic [`FIFO_ADDR_W-1:0] wr_index;
  logic                    rd_accept;
  logic [`FIFO_ADDR_W-1:0] rd_index;

  fifo_wr_ctrl u_wr_ctrl (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_en     (wr_en),
    .rd_gray   (rd_gray),
    .wr_gray   (wr_gray),
    .wr_accept (wr_accept),
    .wr_index  (wr_index),
    .full      (full),
    .afull     (afull)
  );

  fifo_rd_ctrl u_rd_ctrl (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_gray   (wr_gray),
    .rd_gray   (rd_gray),
    .rd_accept (rd_accept),
    .rd_index  (rd_index),
    .empty     (empty),
    .aempty    (aempty)
  );

  fifo_dpram u_dpram (
    .wr_clk    (wr_clk),
    .wr_accept (wr_accept),
    .wr_index  (wr_index),
    .wr_data   (wr_data),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_accept (rd_accept),
    .rd_index  (rd_index),
    .rd_data   (rd_data)
  );

endmodule

/* tb_async_fifo.sv */
`timescale 1ns/10ps
`include "fifo_config.svh"

module tb_async_fifo;

  localparam int WAIT_LIMIT    = 50;
  localparam int DRAIN_LIMIT   = 100;
  localparam int STREAM_CYCLES = 200;

  logic                 wr_clk = 1'b0;
  logic                 rd_clk = 1'b0;
  logic                 wr_rst_n;
  logic                 rd_rst_n;
  logic                 wr_en;
  logic                 rd_en;
  fifo_pkg::fifo_data_t wr_data;
  fifo_pkg::fifo_data_t rd_data;
  logic                 full;
  logic                 afull;
  logic                 empty;
  logic                 aempty;

  fifo_pkg::fifo_data_t model [$];
  integer               seed;
  int                   errors;

  async_fifo UUT (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .wr_en    (wr_en),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .rd_en    (rd_en),
    .rd_data  (rd_data),
    .full     (full),
    .afull    (afull),
    .empty    (empty),
    .aempty   (aempty)
  );

  // Unrelated periods for the two domains.
  always #5 wr_clk = ~wr_clk;
  always #7 rd_clk = ~rd_clk;

  // ********************
  // Compare tasks
  // ********************

  task automatic check_data(input string name, input fifo_pkg::fifo_data_t expected,
                            input fifo_pkg::fifo_data_t actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("FAILED at time %0t: %s expected %b, actual %b", $time, name, expected, actual);
      errors++;
    end
  endtask

  // ********************
  // Bus tasks
  // ********************

  // The DUT decides on the edge with the full value that is stable now.
  task automatic drive_write(input fifo_pkg::fifo_data_t data, output logic accepted);
    @(posedge wr_clk);
    #1;
    wr_en    = 1'b1;
    wr_data  = data;
    accepted = !full;
    if (accepted) begin
      model.push_back(data);
    end
    @(posedge wr_clk);
    #1;
    wr_en = 1'b0;
  endtask

  task automatic drive_read(output logic taken);
    fifo_pkg::fifo_data_t expected;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b1;
    taken = !empty;
    @(posedge rd_clk);
    #1;
    rd_en = 1'b0;
    if (taken) begin
      if (model.size() == 0) begin
        $display("A read was accepted while the reference queue was empty");
        errors++;
      end else begin
        expected = model.pop_front();
        check_data("rd_data", expected, rd_data);
      end
    end
  endtask

  task automatic settle_wr_flags(input logic exp_full, input logic exp_afull);
    int cycles;
    cycles = 0;
    while ((full !== exp_full || afull !== exp_afull) && cycles < WAIT_LIMIT) begin
      @(posedge wr_clk);
      #1;
      cycles++;
    end
    if (full !== exp_full || afull !== exp_afull) begin
      $display("Timeout while waiting for full and afull to settle");
      errors++;
    end
    check_flag("full", exp_full, full);
    check_flag("afull", exp_afull, afull);
  endtask

  task automatic settle_rd_flags(input logic exp_empty, input logic exp_aempty);
    int cycles;
    cycles = 0;
    while ((empty !== exp_empty || aempty !== exp_aempty) && cycles < WAIT_LIMIT) begin
      @(posedge rd_clk);
      #1;
      cycles++;
    end
    if (empty !== exp_empty || aempty !== exp_aempty) begin
      $display("Timeout while waiting for empty and aempty to settle");
      errors++;
    end
    check_flag("empty", exp_empty, empty);
    check_flag("aempty", exp_aempty, aempty);
  endtask

  task automatic drain();
    int   tries;
    logic taken;
    tries = 0;
    while (model.size() > 0 && tries < DRAIN_LIMIT) begin
      drive_read(taken);
      tries++;
    end
    if (model.size() > 0) begin
      $display("Timeout while draining the FIFO, %0d words left", model.size());
      errors++;
    end
    settle_rd_flags(1'b1, 1'b1);
    // Write-side flags clear once the last read has crossed over.
    settle_wr_flags(1'b0, 1'b0);
  endtask

  task automatic check_levels();
    settle_wr_flags(model.size() == `FIFO_DEPTH, model.size() >= `FIFO_AFULL);
    settle_rd_flags(model.size() == 0, model.size() <= `FIFO_AEMPTY);
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic test_reset();
    check_flag("full", 1'b0, full);
    check_flag("afull", 1'b0, afull);
    check_flag("empty", 1'b1, empty);
    check_flag("aempty", 1'b1, aempty);
    check_data("rd_data", '0, rd_data);
  endtask

  task automatic test_order();
    logic ok;
    for (int i = 0; i < 5; i++) begin
      drive_write(fifo_pkg::fifo_data_t'($random(seed)), ok);
      if (!ok) begin
        $display("A write was refused while the FIFO was not full");
        errors++;
      end
    end
    settle_rd_flags(1'b0, 1'b0);
    drain();
  endtask

  task automatic test_full();
    int   accepted_cnt;
    int   tries;
    logic ok;
    accepted_cnt = 0;
    tries = 0;
    while (full !== 1'b1 && tries < 4 * `FIFO_DEPTH) begin
      drive_write(fifo_pkg::fifo_data_t'($random(seed)), ok);
      if (ok) begin
        accepted_cnt++;
      end
      tries++;
    end
    if (full !== 1'b1) begin
      $display("Timeout while waiting for full to rise");
      errors++;
    end
    if (accepted_cnt != `FIFO_DEPTH) begin
      $display("Accepted %0d writes before full instead of %0d", accepted_cnt, `FIFO_DEPTH);
      errors++;
    end
    // Extra write into a full FIFO.
    drive_write(8'hA5, ok);
    if (ok) begin
      $display("A write was accepted while full was high");
      errors++;
    end
    check_flag("full", 1'b1, full);
    drain();
  endtask

  task automatic test_thresholds();
    int   levels [6];
    int   tries;
    logic ok;
    levels = '{0, 1, 2, 14, 15, 16};
    for (int i = 0; i < 6; i++) begin
      tries = 0;
      while (model.size() < levels[i] && tries < 2 * `FIFO_DEPTH) begin
        drive_write(fifo_pkg::fifo_data_t'($random(seed)), ok);
        tries++;
      end
      if (model.size() != levels[i]) begin
        $display("Could not fill the FIFO to %0d words", levels[i]);
        errors++;
      end
      check_levels();
    end
    drain();
  endtask

  task automatic test_stream();
    logic                 rd_bits [256];
    logic                 done;
    logic                 pending;
    fifo_pkg::fifo_data_t pending_word;
    int                   rnd;
    int                   k;
    done    = 1'b0;
    pending = 1'b0;
    k       = 0;
    // Read enables for the whole stream.
    for (int i = 0; i < 256; i++) begin
      rnd = $random(seed);
      rd_bits[i] = rnd[0];
    end
    fork
      begin
        for (int i = 0; i < STREAM_CYCLES; i++) begin
          @(posedge wr_clk);
          #1;
          rnd     = $random(seed);
          wr_en   = rnd[0];
          wr_data = fifo_pkg::fifo_data_t'($random(seed));
          if (wr_en && !full) begin
            model.push_back(wr_data);
          end
        end
        @(posedge wr_clk);
        #1;
        wr_en = 1'b0;
        done  = 1'b1;
      end
      begin
        while (!done && k < 256) begin
          @(posedge rd_clk);
          #1;
          if (pending) begin
            check_data("rd_data", pending_word, rd_data);
          end
          pending = 1'b0;
          rd_en   = rd_bits[k] && !empty;
          k++;
          if (rd_en && model.size() == 0) begin
            $display("empty was low while the reference queue was empty");
            errors++;
          end else if (rd_en) begin
            pending_word = model.pop_front();
            pending      = 1'b1;
          end
        end
        @(posedge rd_clk);
        #1;
        rd_en = 1'b0;
        if (pending) begin
          check_data("rd_data", pending_word, rd_data);
        end
      end
    join
    drain();
    if (model.size() != 0) begin
      $display("The reference queue still holds %0d words", model.size());
      errors++;
    end
    check_flag("empty", 1'b1, empty);
  endtask

  // ********************
  // Main sequence
  // ********************

  initial begin
    seed     = 32'h8170ea74;
    errors   = 0;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_en    = 1'b0;
    rd_en    = 1'b0;
    wr_data  = '0;
    fork
      begin
        repeat (5) @(posedge wr_clk);
        #1;
        wr_rst_n = 1'b1;
      end
      begin
        repeat (5) @(posedge rd_clk);
        #1;
        rd_rst_n = 1'b1;
      end
    join
    test_reset();
    test_order();
    test_full();
    test_thresholds();
    test_stream();
    $display("Errors counted: %0d", errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+.
fifo_pkg.sv
ptr_sync.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
fifo_dpram.sv
async_fifo.sv
tb_async_fifo.sv
